/* alu_exec_cases.txt */
# T name | D slot op tag a a_valid a_tag b b_valid b_tag expected | C port tag data with_next
# F flush | W wait until n results outstanding | S stall_cycles expect_queue_full
T all_ops
D 0 0 1 00000005 1 0 00000003 1 0 00000008
D 0 1 2 00000005 1 0 00000007 1 0 fffffffe
D 0 2 3 f0f0ff00 1 0 0ff0f0f0 1 0 00f0f000
D 0 3 4 12340000 1 0 00005678 1 0 12345678
D 0 4 5 aaaa5555 1 0 ffff0000 1 0 55555555
D 0 5 6 00000001 1 0 00000024 1 0 00000010
D 0 6 7 80000000 1 0 0000001f 1 0 00000001
D 0 7 8 ffffffff 1 0 00000001 1 0 00000001
D 0 7 9 00000001 1 0 ffffffff 1 0 00000000
T slot_one
D 1 0 10 00000005 1 0 00000003 1 0 00000008
D 1 7 11 ffffffff 1 0 00000001 1 0 00000001
T cdb_wait
D 0 0 12 00000000 0 40 00000010 1 0 00000110
C 0 40 00000100 0
C 1 41 00000020 1
D 1 1 13 00000050 1 0 00000000 0 41 00000030
D 0 4 14 00000000 0 42 00000000 0 43 00ffff00
C 0 42 0000ff00 0
C 1 43 00ff0000 0
T no_starve
D 0 0 15 00000000 0 44 00000001 1 0 00000101
D 1 0 16 00000002 1 0 00000002 1 0 00000004
D 0 0 17 00000003 1 0 00000003 1 0 00000006
D 1 2 18 0000000f 1 0 0000003c 1 0 0000000c
D 0 3 19 00000001 1 0 00000002 1 0 00000003
C 1 44 00000100 0
T back_pressure
W 0
S 40 1
D 0 0 20 00000014 1 0 00001000 1 0 00001014
D 1 0 21 00000015 1 0 00001000 1 0 00001015
D 0 0 22 00000016 1 0 00001000 1 0 00001016
D 1 0 23 00000017 1 0 00001000 1 0 00001017
D 0 0 24 00000018 1 0 00001000 1 0 00001018
D 1 0 25 00000019 1 0 00001000 1 0 00001019
D 0 0 26 0000001a 1 0 00001000 1 0 0000101a
D 1 0 27 0000001b 1 0 00001000 1 0 0000101b
D 0 0 28 0000001c 1 0 00001000 1 0 0000101c
D 1 0 29 0000001d 1 0 00001000 1 0 0000101d
D 0 0 30 0000001e 1 0 00001000 1 0 0000101e
T flush
W 0
S 30 0
# two entries wait on tags that never come, two results sit behind the stall
D 0 0 32 00000000 0 45 00000001 1 0 00000001
D 1 0 33 00000000 0 46 00000001 1 0 00000001
D 0 0 34 00000001 1 0 00000001 1 0 00000002
D 1 0 35 00000002 1 0 00000001 1 0 00000003
F
C 0 45 00000005 0
D 0 1 36 00000009 1 0 00000004 1 0 00000005
D 1 6 37 00000100 1 0 00000004 1 0 00000010
D 0 0 38 00000000 0 47 00000003 1 0 0000000a
C 0 47 00000007 0

/* alu_exec_top.f */
+incdir+.
alu_iq_pkg.sv
iq_entry.sv
iq_age_select.sv
iq_alu.sv
alu_iq.sv
result_fifo.sv
alu_exec_top.sv
alu_exec_tb.sv

/* alu_exec_tb.sv */
`timescale 1ns/1ps
`include "alu_iq_defines.svh"

module alu_exec_tb;
    import alu_iq_pkg::*;

    localparam CASE_FILE    = "alu_exec_cases.txt";
    localparam CYCLES_PER_LINE = 200;

    logic                                        clk;
    logic                                        rst_n_i;
    logic                                        flush_i;
    logic [`DISPATCH_CNT-1:0]                    choose_i;
    decode_info_t [`DISPATCH_CNT-1:0]            disp_di_i;
    word_t   [`DISPATCH_CNT-1:0][`REG_COUNT-1:0] disp_data_i;
    rob_id_t [`DISPATCH_CNT-1:0][`REG_COUNT-1:0] disp_tag_i;
    logic    [`DISPATCH_CNT-1:0][`REG_COUNT-1:0] disp_valid_i;
    word_t   [`CDB_COUNT-1:0]                    cdb_data_i;
    rob_id_t [`CDB_COUNT-1:0]                    cdb_tag_i;
    logic    [`CDB_COUNT-1:0]                    cdb_valid_i;
    logic                                        queue_ready_o;
    cdb_info_t                                   result_o;
    logic                                        res_valid_o;
    logic                                        res_ready_i;

    // scoreboard, indexed by ROB tag
    logic          exp_valid [64];
    word_t         exp_data  [64];
    integer        outstanding;

    // result stall and CDB held back for the next dispatch
    integer        stall_left;
    logic          stall_check;
    logic          qr_low_seen;
    logic          cdb_join;
    integer        join_port;
    rob_id_t       join_tag;
    word_t         join_data;

    integer        seed = 32'h2dfb_2efd;
    integer        limit_cycles;
    reg [8*32-1:0] test_name;

    alu_exec_top dut (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .choose_i      (choose_i),
        .disp_di_i     (disp_di_i),
        .disp_data_i   (disp_data_i),
        .disp_tag_i    (disp_tag_i),
        .disp_valid_i  (disp_valid_i),
        .cdb_data_i    (cdb_data_i),
        .cdb_tag_i     (cdb_tag_i),
        .cdb_valid_i   (cdb_valid_i),
        .queue_ready_o (queue_ready_o),
        .result_o      (result_o),
        .res_valid_o   (res_valid_o),
        .res_ready_i   (res_ready_i)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------
    // failure reporting and value compare
    task automatic abort_run(input string msg);
        $display("%0s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_val(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("[ERROR] test %0s: %0s expected %h actual %h",
                                test_name, what, expected, actual));
        end
    endtask

    task automatic take_result(input cdb_info_t r);
        if (!exp_valid[r.rob_id]) begin
            abort_run($sformatf("test %0s: result with tag %0d was not expected or came twice",
                                test_name, r.rob_id));
        end
        check_val($sformatf("w_data of tag %0d", r.rob_id), exp_data[r.rob_id], r.w_data);
        check_val($sformatf("r_valid of tag %0d", r.rob_id), 32'd1, {31'b0, r.r_valid});
        check_val($sformatf("w_reg of tag %0d", r.rob_id), 32'd1, {31'b0, r.w_reg});
        exp_valid[r.rob_id] = 1'b0;
        outstanding = outstanding - 1;
    endtask

    // ------------------------------------------------------------
    // stimulus tasks, all entered 1 ns after a rising edge
    task automatic send_dispatch(input integer slot, input integer op, input integer tag,
                                 input word_t a, input integer va, input integer ta,
                                 input word_t b, input integer vb, input integer tb,
                                 input word_t ex);
        decode_info_t di;
        if (exp_valid[tag]) begin
            abort_run($sformatf("test %0s: tag %0d dispatched while still in flight",
                                test_name, tag));
        end
        di            = '0;
        di.inst_valid = 1'b1;
        di.op         = alu_op_t'(op);
        di.wreg       = 1'b1;
        di.wreg_id    = rob_id_t'(tag);
        di.pc         = 32'h0000_1000 + tag * 4;
        exp_valid[tag] = 1'b1;
        exp_data[tag]  = ex;
        outstanding    = outstanding + 1;
        while (!queue_ready_o) begin
            @(posedge clk);
            #1;
        end
        disp_di_i[slot]       = di;
        disp_data_i[slot][0]  = a;
        disp_data_i[slot][1]  = b;
        disp_tag_i[slot][0]   = rob_id_t'(ta);
        disp_tag_i[slot][1]   = rob_id_t'(tb);
        disp_valid_i[slot][0] = va[0];
        disp_valid_i[slot][1] = vb[0];
        choose_i              = '0;
        choose_i[slot]        = 1'b1;
        if (cdb_join) begin
            cdb_valid_i[join_port] = 1'b1;
            cdb_tag_i[join_port]   = join_tag;
            cdb_data_i[join_port]  = join_data;
            cdb_join               = 1'b0;
        end
        @(posedge clk);
        #1;
        choose_i    = '0;
        cdb_valid_i = '0;
    endtask

    task automatic send_cdb(input integer port, input integer tag, input word_t data);
        cdb_valid_i[port] = 1'b1;
        cdb_tag_i[port]   = rob_id_t'(tag);
        cdb_data_i[port]  = data;
        @(posedge clk);
        #1;
        cdb_valid_i = '0;
    endtask

    task automatic wait_outstanding(input integer n);
        while (outstanding != n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic do_flush();
        // whatever is still in flight is dropped by the flush
        for (int t = 0; t < 64; t++) begin
            exp_valid[t] = 1'b0;
        end
        outstanding = 0;
        flush_i     = 1'b1;
        @(posedge clk);
        #1;
        flush_i = 1'b0;
        check_val("res_valid_o after flush", 32'd0, {31'b0, res_valid_o});
        check_val("queue_ready_o after flush", 32'd1, {31'b0, queue_ready_o});
    endtask

    // ------------------------------------------------------------
    // result reader with random back-pressure
    initial begin : reader
        wait (rst_n_i === 1'b1);
        forever begin
            @(posedge clk);
            #1;
            if (stall_left > 0) begin
                res_ready_i = 1'b0;
                stall_left  = stall_left - 1;
                if (stall_left == 0 && stall_check) begin
                    check_val("queue_ready_o low during stall", 32'd1, {31'b0, qr_low_seen});
                    stall_check = 1'b0;
                end
            end else begin
                res_ready_i = (($random(seed) & 3) != 0);
            end
            @(negedge clk);
            if (stall_left > 0 && !queue_ready_o) begin
                qr_low_seen = 1'b1;
            end
            if (res_valid_o && res_ready_i && !flush_i) begin
                take_result(result_o);
            end
        end
    end

    initial begin : watchdog
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        abort_run("timeout: not every dispatched instruction produced a result");
    end

    // ------------------------------------------------------------
    // main sequence, driven by the case file
    initial begin : main
        integer        fd;
        integer        r;
        integer        n_lines;
        integer        slot, op, tag, va, ta, vb, tb, port, joint, n, q;
        word_t         a, b, ex, data;
        reg [8*8-1:0]  kind;
        reg [8*128-1:0] line;

        rst_n_i      = 1'b0;
        flush_i      = 1'b0;
        choose_i     = '0;
        disp_di_i    = '0;
        disp_data_i  = '0;
        disp_tag_i   = '0;
        disp_valid_i = '0;
        cdb_data_i   = '0;
        cdb_tag_i    = '0;
        cdb_valid_i  = '0;
        res_ready_i  = 1'b0;
        outstanding  = 0;
        stall_left   = 0;
        stall_check  = 1'b0;
        qr_low_seen  = 1'b0;
        cdb_join     = 1'b0;
        limit_cycles = 0;
        test_name    = "reset";
        for (int t = 0; t < 64; t++) begin
            exp_valid[t] = 1'b0;
            exp_data[t]  = '0;
        end

        // count lines to size the watchdog
        n_lines = 0;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            abort_run("could not open the case file");
        end
        while (!$feof(fd)) begin
            r = $fgets(line, fd);
            if (r != 0) begin
                n_lines = n_lines + 1;
            end
        end
        $fclose(fd);
        limit_cycles = (n_lines + 1) * CYCLES_PER_LINE;

        repeat (10) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        @(posedge clk);
        #1;

        fd = $fopen(CASE_FILE, "r");
        while ($fscanf(fd, "%s", kind) == 1) begin
            if (kind == "#") begin
                r = $fgets(line, fd);
            end else if (kind == "T") begin
                r = $fscanf(fd, "%s", test_name);
            end else if (kind == "D") begin
                r = $fscanf(fd, "%d %d %d %h %d %d %h %d %d %h",
                            slot, op, tag, a, va, ta, b, vb, tb, ex);
                if (r != 10 || slot >= `DISPATCH_CNT) begin
                    abort_run("malformed dispatch line in the case file");
                end
                send_dispatch(slot, op, tag, a, va, ta, b, vb, tb, ex);
            end else if (kind == "C") begin
                r = $fscanf(fd, "%d %d %h %d", port, tag, data, joint);
                if (r != 4 || port >= `CDB_COUNT) begin
                    abort_run("malformed CDB line in the case file");
                end
                if (joint != 0) begin
                    cdb_join  = 1'b1;
                    join_port = port;
                    join_tag  = rob_id_t'(tag);
                    join_data = data;
                end else begin
                    send_cdb(port, tag, data);
                end
            end else if (kind == "F") begin
                do_flush();
            end else if (kind == "W") begin
                r = $fscanf(fd, "%d", n);
                wait_outstanding(n);
            end else if (kind == "S") begin
                r = $fscanf(fd, "%d %d", n, q);
                qr_low_seen = 1'b0;
                stall_check = q[0];
                stall_left  = n;
            end else begin
                abort_run("unknown line kind in the case file");
            end
        end
        $fclose(fd);

        wait_outstanding(0);
        // stray results would show up here
        repeat (20) @(posedge clk);
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* alu_exec_top.sv */
`timescale 1ns/1ps
`include "alu_iq_defines.svh"

module alu_exec_top (
    input  logic                                                    clk,
    input  logic                                                    rst_n_i,
    input  logic                                                    flush_i,
    input  logic [`DISPATCH_CNT-1:0]                                choose_i,
    input  alu_iq_pkg::decode_info_t [`DISPATCH_CNT-1:0]            disp_di_i,
    input  alu_iq_pkg::word_t   [`DISPATCH_CNT-1:0][`REG_COUNT-1:0] disp_data_i,
    input  alu_iq_pkg::rob_id_t [`DISPATCH_CNT-1:0][`REG_COUNT-1:0] disp_tag_i,
    input  logic                [`DISPATCH_CNT-1:0][`REG_COUNT-1:0] disp_valid_i,
    input  alu_iq_pkg::word_t   [`CDB_COUNT-1:0]                    cdb_data_i,
    input  alu_iq_pkg::rob_id_t [`CDB_COUNT-1:0]                    cdb_tag_i,
    input  logic                [`CDB_COUNT-1:0]                    cdb_valid_i,
    output logic                                                    queue_ready_o,
    output alu_iq_pkg::cdb_info_t                                   result_o,
    output logic                                                    res_valid_o,
    input  logic                                                    res_ready_i
);
    import alu_iq_pkg::*;

    logic      fifo_ready;
    logic      exec_valid;
    cdb_info_t exec_result;

    alu_iq u_iq (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .choose_i      (choose_i),
        .disp_di_i     (disp_di_i),
        .disp_data_i   (disp_data_i),
        .disp_tag_i    (disp_tag_i),
        .disp_valid_i  (disp_valid_i),
        .cdb_data_i    (cdb_data_i),
        .cdb_tag_i     (cdb_tag_i),
        .cdb_valid_i   (cdb_valid_i),
        .queue_ready_o (queue_ready_o),
        .fifo_ready_i  (fifo_ready),
        .exec_valid_o  (exec_valid),
        .result_o      (exec_result)
    );

    result_fifo u_fifo (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .push_i  (exec_valid),
        .din_i   (exec_result),
        .ready_o (fifo_ready),
        .pop_i   (res_ready_i),
        .valid_o (res_valid_o),
        .dout_o  (result_o)
    );

endmodule

/* result_fifo.sv */
`timescale 1ns/1ps
`include "alu_iq_defines.svh"

module result_fifo (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    input  logic                  push_i,
    input  alu_iq_pkg::cdb_info_t din_i,
    output logic                  ready_o,
    input  logic                  pop_i,
    output logic                  valid_o,
    output alu_iq_pkg::cdb_info_t dout_o
);
    import alu_iq_pkg::*;

    localparam int DEPTH = `RES_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    cdb_info_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;
    logic             wr_en;
    logic             rd_en;

    assign ready_o = (count_q != (PTR_W+1)'(DEPTH));
    assign valid_o = (count_q != '0);
    assign wr_en   = push_i && ready_o;
    assign rd_en   = pop_i && valid_o;
    assign dout_o  = mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (rd_en) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + (PTR_W+1)'(wr_en) - (PTR_W+1)'(rd_en);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr_q] <= din_i;
        end
    end

    // a push that meets a full buffer is held unchanged, so none is dropped
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rst_n_i || flush_i)
        (push_i && !ready_o) |=> (push_i && $stable(din_i))
    );

endmodule

/* alu_iq.sv */
`timescale 1ns/1ps
`include "alu_iq_defines.svh"

module alu_iq (
    input  logic                                                    clk,
    input  logic                                                    rst_n_i,
    input  logic                                                    flush_i,
    input  logic [`DISPATCH_CNT-1:0]                                choose_i,
    input  alu_iq_pkg::decode_info_t [`DISPATCH_CNT-1:0]            disp_di_i,
    input  alu_iq_pkg::word_t   [`DISPATCH_CNT-1:0][`REG_COUNT-1:0] disp_data_i,
    input  alu_iq_pkg::rob_id_t [`DISPATCH_CNT-1:0][`REG_COUNT-1:0] disp_tag_i,
    input  logic                [`DISPATCH_CNT-1:0][`REG_COUNT-1:0] disp_valid_i,
    input  alu_iq_pkg::word_t   [`CDB_COUNT-1:0]                    cdb_data_i,
    input  alu_iq_pkg::rob_id_t [`CDB_COUNT-1:0]                    cdb_tag_i,
    input  logic                [`CDB_COUNT-1:0]                    cdb_valid_i,
    output logic                                                    queue_ready_o,
    input  logic                                                    fifo_ready_i,
    output logic                                                    exec_valid_o,
    output alu_iq_pkg::cdb_info_t                                   result_o
);
    import alu_iq_pkg::*;

    localparam int CNT_W = $clog2(`IQ_SIZE) + 1;

    // ------------------------------------------------------------
    // dispatch mux, choose is one-hot or zero
    decode_info_t               in_di;
    word_t   [`REG_COUNT-1:0]   in_data;
    rob_id_t [`REG_COUNT-1:0]   in_tag;
    logic    [`REG_COUNT-1:0]   in_valid;
    logic                       dispatch;

    always_comb begin
        in_di    = '0;
        in_data  = '0;
        in_tag   = '0;
        in_valid = '0;
        for (int s = 0; s < `DISPATCH_CNT; s++) begin
            if (choose_i[s]) begin
                in_di    |= disp_di_i[s];
                in_data  |= disp_data_i[s];
                in_tag   |= disp_tag_i[s];
                in_valid |= disp_valid_i[s];
            end
        end
    end

    assign dispatch = |choose_i;

    // ------------------------------------------------------------
    // entries and allocation
    logic [`IQ_SIZE-1:0]                    entry_busy;
    logic [`IQ_SIZE-1:0]                    entry_ready;
    logic [`IQ_SIZE-1:0]                    entry_init;
    logic [`IQ_SIZE-1:0]                    grant;
    decode_info_t [`IQ_SIZE-1:0]            entry_di;
    word_t [`IQ_SIZE-1:0][`REG_COUNT-1:0]   entry_data;

    // lowest free entry takes the instruction
    always_comb begin
        logic found;
        found      = 1'b0;
        entry_init = '0;
        for (int i = 0; i < `IQ_SIZE; i++) begin
            if (!entry_busy[i] && !found) begin
                entry_init[i] = dispatch;
                found         = 1'b1;
            end
        end
    end

    for (genvar i = 0; i < `IQ_SIZE; i++) begin : gen_entry
        iq_entry u_entry (
            .clk         (clk),
            .rst_n_i     (rst_n_i),
            .flush_i     (flush_i),
            .init_i      (entry_init[i]),
            .select_i    (grant[i]),
            .di_i        (in_di),
            .data_i      (in_data),
            .tag_i       (in_tag),
            .valid_i     (in_valid),
            .cdb_data_i  (cdb_data_i),
            .cdb_tag_i   (cdb_tag_i),
            .cdb_valid_i (cdb_valid_i),
            .busy_o      (entry_busy[i]),
            .ready_o     (entry_ready[i]),
            .di_o        (entry_di[i]),
            .data_o      (entry_data[i])
        );
    end

    // ------------------------------------------------------------
    // free count and queue ready
    logic [CNT_W-1:0] free_cnt_q;
    logic [CNT_W-1:0] free_cnt_d;
    logic             queue_ready_q;

    assign free_cnt_d = free_cnt_q - CNT_W'(dispatch) + CNT_W'(|grant);

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            free_cnt_q    <= CNT_W'(`IQ_SIZE);
            queue_ready_q <= 1'b1;
        end else begin
            free_cnt_q    <= free_cnt_d;
            queue_ready_q <= (free_cnt_d != '0);
        end
    end

    assign queue_ready_o = queue_ready_q;

    // ------------------------------------------------------------
    // issue pipeline: execute register, then result register
    logic                       ex_vld_q;
    logic                       res_vld_q;
    logic                       ex_adv;
    logic                       res_adv;
    decode_info_t               sel_di;
    word_t   [`REG_COUNT-1:0]   sel_data;
    decode_info_t               ex_di_q;
    word_t   [`REG_COUNT-1:0]   ex_data_q;
    word_t                      alu_res;
    cdb_info_t                  res_q;

    assign res_adv = !res_vld_q || fifo_ready_i;
    assign ex_adv  = !ex_vld_q || res_adv;

    iq_age_select u_select (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .entry_ready_i (entry_ready),
        .advance_i     (ex_adv),
        .grant_o       (grant)
    );

    always_comb begin
        sel_di   = '0;
        sel_data = '0;
        for (int i = 0; i < `IQ_SIZE; i++) begin
            if (grant[i]) begin
                sel_di   |= entry_di[i];
                sel_data |= entry_data[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            ex_vld_q  <= 1'b0;
            res_vld_q <= 1'b0;
        end else begin
            if (ex_adv) begin
                ex_vld_q <= |grant;
            end
            if (res_adv) begin
                res_vld_q <= ex_vld_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ex_adv) begin
            ex_di_q   <= sel_di;
            ex_data_q <= sel_data;
        end
        if (res_adv) begin
            res_q.r_valid <= ex_di_q.inst_valid;
            res_q.w_reg   <= ex_di_q.wreg;
            res_q.rob_id  <= ex_di_q.wreg_id;
            res_q.w_data  <= alu_res;
        end
    end

    iq_alu u_alu (
        .op_i     (ex_di_q.op),
        .a_i      (ex_data_q[0]),
        .b_i      (ex_data_q[1]),
        .result_o (alu_res)
    );

    assign exec_valid_o = res_vld_q;
    assign result_o     = res_q;

    // dispatch only while the registered ready was high
    a_choose_when_ready: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        dispatch |-> queue_ready_o
    );

    a_free_cnt_range: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        free_cnt_q <= CNT_W'(`IQ_SIZE)
    );

endmodule

/* iq_alu.sv */
`timescale 1ns/1ps

module iq_alu (
    input  alu_iq_pkg::alu_op_t op_i,
    input  alu_iq_pkg::word_t   a_i,
    input  alu_iq_pkg::word_t   b_i,
    output alu_iq_pkg::word_t   result_o
);
    import alu_iq_pkg::*;

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        result_o = '0;
        case (op_i)
            ALU_ADD: result_o = a_i + b_i;
            ALU_SUB: result_o = a_i - b_i;
            ALU_AND: result_o = a_i & b_i;
            ALU_OR:  result_o = a_i | b_i;
            ALU_XOR: result_o = a_i ^ b_i;
            ALU_SLL: result_o = a_i << shamt;
            ALU_SRL: result_o = a_i >> shamt;
            // signed less-than, zero extended
            ALU_SLT: result_o = {31'b0, $signed(a_i) < $signed(b_i)};
            default: result_o = '0;
        endcase
    end

endmodule

/* iq_age_select.sv */
`timescale 1ns/1ps
`include "alu_iq_defines.svh"

module iq_age_select (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 flush_i,
    input  logic [`IQ_SIZE-1:0]  entry_ready_i,
    input  logic                 advance_i,
    output logic [`IQ_SIZE-1:0]  grant_o
);

    logic [`AGING_LEN-1:0] age_q [`IQ_SIZE];
    logic [`AGING_LEN:0]   key   [`IQ_SIZE];
    logic [1:0]            win_lo;
    logic [1:0]            win_hi;
    logic [1:0]            win;

    // ------------------------------------------------------------
    // oldest-ready tree with ties going to the lower index
    always_comb begin
        for (int i = 0; i < `IQ_SIZE; i++) begin
            key[i] = {entry_ready_i[i], age_q[i]};
        end
        win_lo = (key[1] > key[0]) ? 2'd1 : 2'd0;
        win_hi = (key[3] > key[2]) ? 2'd3 : 2'd2;
        win    = (key[win_hi] > key[win_lo]) ? win_hi : win_lo;

        grant_o      = '0;
        grant_o[win] = entry_ready_i[win] & advance_i;
    end

    // ------------------------------------------------------------
    // one-hot aging that saturates at the top bit
    always_ff @(posedge clk) begin
        for (int i = 0; i < `IQ_SIZE; i++) begin
            if (!rst_n_i || flush_i || grant_o[i]) begin
                age_q[i] <= '0;
            end else if (age_q[i] == '0) begin
                age_q[i] <= 'd1;
            end else if (!age_q[i][`AGING_LEN-1]) begin
                age_q[i] <= age_q[i] << 1;
            end
        end
    end

    // a ready entry is never passed over while the stage can advance
    a_grant_legal: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (advance_i && (|entry_ready_i)) |-> (grant_o != '0)
    );

endmodule

/* iq_entry.sv */
`timescale 1ns/1ps
`include "alu_iq_defines.svh"

module iq_entry (
    input  logic                                         clk,
    input  logic                                         rst_n_i,
    input  logic                                         flush_i,
    input  logic                                         init_i,
    input  logic                                         select_i,
    input  alu_iq_pkg::decode_info_t                     di_i,
    input  alu_iq_pkg::word_t   [`REG_COUNT-1:0]         data_i,
    input  alu_iq_pkg::rob_id_t [`REG_COUNT-1:0]         tag_i,
    input  logic                [`REG_COUNT-1:0]         valid_i,
    input  alu_iq_pkg::word_t   [`CDB_COUNT-1:0]         cdb_data_i,
    input  alu_iq_pkg::rob_id_t [`CDB_COUNT-1:0]         cdb_tag_i,
    input  logic                [`CDB_COUNT-1:0]         cdb_valid_i,
    output logic                                         busy_o,
    output logic                                         ready_o,
    output alu_iq_pkg::decode_info_t                     di_o,
    output alu_iq_pkg::word_t   [`REG_COUNT-1:0]         data_o
);
    import alu_iq_pkg::*;

    logic                   busy_q;
    logic [`REG_COUNT-1:0]  op_valid_q;
    decode_info_t           di_q;
    word_t   [`REG_COUNT-1:0] data_q;
    rob_id_t [`REG_COUNT-1:0] tag_q;

    // CDB match per operand
    rob_id_t [`REG_COUNT-1:0] cmp_tag;
    logic    [`REG_COUNT-1:0] hit;
    word_t   [`REG_COUNT-1:0] hit_data;

    always_comb begin
        hit      = '0;
        hit_data = '0;
        for (int r = 0; r < `REG_COUNT; r++) begin
            // compare the incoming tag on init, the stored one otherwise
            cmp_tag[r] = init_i ? tag_i[r] : tag_q[r];
            for (int c = 0; c < `CDB_COUNT; c++) begin
                if (cdb_valid_i[c] && (cdb_tag_i[c] == cmp_tag[r])) begin
                    hit[r]      = 1'b1;
                    hit_data[r] = cdb_data_i[c];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            busy_q     <= 1'b0;
            op_valid_q <= '0;
        end else if (init_i) begin
            busy_q     <= 1'b1;
            op_valid_q <= valid_i | hit;
        end else if (select_i) begin
            busy_q     <= 1'b0;
        end else if (busy_q) begin
            op_valid_q <= op_valid_q | hit;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (init_i) begin
            di_q  <= di_i;
            tag_q <= tag_i;
        end
        for (int r = 0; r < `REG_COUNT; r++) begin
            if (init_i) begin
                data_q[r] <= valid_i[r] ? data_i[r] : hit_data[r];
            end else if (busy_q && !op_valid_q[r] && hit[r]) begin
                data_q[r] <= hit_data[r];
            end
        end
    end

    assign busy_o  = busy_q;
    assign ready_o = busy_q && (&op_valid_q);
    assign di_o    = di_q;
    assign data_o  = data_q;

    // allocation only targets a free entry, issue only a busy one
    a_init_select_excl: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !(init_i && select_i)
    );

endmodule

/* alu_iq_pkg.sv */
package alu_iq_pkg;

    typedef logic [31:0] word_t;
    typedef logic [5:0]  rob_id_t;
    typedef logic [2:0]  alu_op_t;

    // ALU opcodes
    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_XOR = 3'd4;
    localparam alu_op_t ALU_SLL = 3'd5;
    localparam alu_op_t ALU_SRL = 3'd6;
    localparam alu_op_t ALU_SLT = 3'd7;

    // decoded instruction as it enters the queue
    typedef struct packed {
        logic    inst_valid;
        alu_op_t op;
        logic    wreg;
        rob_id_t wreg_id;
        word_t   pc;
    } decode_info_t;

    // finished result, queued and sent out
    typedef struct packed {
        logic    r_valid;
        logic    w_reg;
        rob_id_t rob_id;
        word_t   w_data;
    } cdb_info_t;

endpackage

/* alu_iq_defines.svh */
`ifndef ALU_IQ_DEFINES_SVH
`define ALU_IQ_DEFINES_SVH

// queue geometry
// the selector tree is built for exactly four entries
`define IQ_SIZE         4
`define AGING_LEN       4

// dispatch and operand counts
`define DISPATCH_CNT    2
`define REG_COUNT       2

// broadcast ports
`define CDB_COUNT       2

// result buffer
`define RES_FIFO_DEPTH  4

`endif
